// ==== Bender.yml ====
package:
  name: plotter

sources:
  - plotter_pkg.sv
  - step_if.sv
  - cmd_decoder.sv
  - int_sqrt.sv
  - arc_stepper.sv
  - position_tracker.sv
  - plotter_top.sv
  - target: simulation
    files:
      - tb_plotter.sv

// ==== arc_stepper.sv ====
`timescale 1ns/1ns
`default_nettype none

module arc_stepper (
	input logic clk,
	input logic reset,
	input plotter_pkg::cmd_t cmd,
	input logic cmd_ready,
	step_if.stepper step,
	output logic busy,
	output logic done,
	output logic error,
	output logic [plotter_pkg::count_bits-1:0] step_count
);
	import plotter_pkg::*;

	arc_state_t state;
	cmd_t cmd_q;
	quadrant_t quad;
	logic is_cw;
	logic signed [pos_bits+1:0] cx; // centre may lie off the grid.
	logic signed [pos_bits+1:0] cy;
	logic [sq_bits-1:0] r_sq;
	logic [sq_bits-1:0] r_sq_calc;
	logic [count_bits-1:0] limit;
	logic sqrt_done;
	logic [pos_bits:0] root;
	logic signed [sq_bits+1:0] rel_x, rel_y, cand_x, cand_y;
	logic signed [sq_bits+1:0] err_x, err_y, abs_x, abs_y;
	logic x_neg, y_neg, pick_x, at_end;

	int_sqrt sqrt_i (
		.clk(clk),
		.reset(reset),
		.start(state == load),
		.radicand(r_sq_calc),
		.root(root),
		.done(sqrt_done)
	);

	assign busy = (state != idle) || cmd_ready;
	assign is_cw = (cmd_q.opcode == op_arc_cw);
	assign r_sq_calc = $signed(cmd_q.i) * $signed(cmd_q.i) + $signed(cmd_q.j) * $signed(cmd_q.j);

	// a full circle starts on its end point, so at least one step is needed.
	assign at_end = (step.cur_x == cmd_q.x) && (step.cur_y == cmd_q.y) && (step_count != '0);

	always_comb begin
		rel_x = $signed({1'b0, step.cur_x}) - cx;
		rel_y = $signed({1'b0, step.cur_y}) - cy;
		// axis points go to the quadrant being entered.
		if (is_cw) begin
			if (rel_x >= 0 && rel_y > 0) quad = q1;
			else if (rel_x < 0 && rel_y >= 0) quad = q2;
			else if (rel_x <= 0 && rel_y < 0) quad = q3;
			else quad = q4;
		end else begin
			if (rel_x > 0 && rel_y >= 0) quad = q1;
			else if (rel_x <= 0 && rel_y > 0) quad = q2;
			else if (rel_x < 0 && rel_y <= 0) quad = q3;
			else quad = q4;
		end
		x_neg = (quad == q3 || quad == q4) ^ !is_cw; // ccw mirrors cw.
		y_neg = (quad == q1 || quad == q4) ^ !is_cw;
		cand_x = x_neg ? rel_x - 1 : rel_x + 1;
		cand_y = y_neg ? rel_y - 1 : rel_y + 1;
		err_x = cand_x * cand_x + rel_y * rel_y - $signed({2'b00, r_sq});
		err_y = rel_x * rel_x + cand_y * cand_y - $signed({2'b00, r_sq});
		abs_x = (err_x < 0) ? -err_x : err_x;
		abs_y = (err_y < 0) ? -err_y : err_y;
		pick_x = (abs_x <= abs_y); // tie goes to x.
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			done <= 1'b0;
			error <= 1'b0;
			step_count <= '0;
			step.step_req <= 1'b0;
			step.move_req <= 1'b0;
		end else begin
			done <= 1'b0;
			step.step_req <= 1'b0;
			step.move_req <= 1'b0;
			case (state)
				idle: if (cmd_ready) begin
					error <= 1'b0;
					step_count <= '0;
					if (!cmd.valid) begin
						error <= 1'b1; // no motion.
						state <= finish;
					end else if (cmd.opcode == op_move) begin
						step.move_req <= 1'b1;
						state <= finish;
					end else begin
						state <= load;
					end
				end
				load: state <= sqrt_wait;
				sqrt_wait: if (sqrt_done) state <= plotter_pkg::step;
				plotter_pkg::step: begin
					if (at_end) begin
						state <= finish;
					end else if (step_count == limit) begin
						error <= 1'b1; // end point never reached.
						state <= finish;
					end else begin
						step.step_req <= 1'b1;
						step_count <= step_count + 1'b1;
						state <= wait_ack;
					end
				end
				wait_ack: state <= plotter_pkg::step; // tracker applies the step.
				finish: begin
					done <= 1'b1;
					state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == idle && cmd_ready) begin
			cmd_q <= cmd;
			step.move_x <= cmd.x;
			step.move_y <= cmd.y;
		end
		if (state == load) begin
			cx <= $signed({1'b0, step.cur_x}) + $signed(cmd_q.i);
			cy <= $signed({1'b0, step.cur_y}) + $signed(cmd_q.j);
			r_sq <= r_sq_calc;
		end
		if (sqrt_done) begin
			limit <= {root, 3'b000}; // 8r is the manhattan length of a circle.
		end
		if (state == plotter_pkg::step) begin
			step.step_axis <= !pick_x;
			step.step_neg <= pick_x ? x_neg : y_neg;
		end
	end

	no_overlap_cmd: assert property (@(posedge clk) disable iff (reset)
		cmd_ready |-> state == idle);
	step_after_update: assert property (@(posedge clk) disable iff (reset)
		state == plotter_pkg::step |-> !step.step_req);
	done_single: assert property (@(posedge clk) disable iff (reset)
		done |=> !done);

endmodule

`default_nettype wire

// ==== build.f ====
plotter_pkg.sv
step_if.sv
cmd_decoder.sv
int_sqrt.sv
arc_stepper.sv
position_tracker.sv
plotter_top.sv
tb_plotter.sv

// ==== cmd_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module cmd_decoder (
	input logic clk,
	input logic reset,
	input logic cmd_strobe,
	input logic [plotter_pkg::cmd_bits-1:0] cmd_word,
	output plotter_pkg::cmd_t cmd,
	output logic cmd_ready
);
	import plotter_pkg::*;

	opcode_t op_field;
	cmd_t decoded;

	always_comb begin
		op_field = opcode_t'(cmd_word[cmd_bits-1 -: $bits(opcode_t)]);
		decoded.opcode = op_field;
		decoded.x = cmd_word[4*pos_bits-1 -: pos_bits];
		decoded.y = cmd_word[3*pos_bits-1 -: pos_bits];
		decoded.i = cmd_word[2*off_bits-1 -: off_bits];
		decoded.j = cmd_word[off_bits-1:0];
		case (op_field)
			op_move, op_arc_cw, op_arc_ccw: decoded.valid = 1'b1;
			default: decoded.valid = 1'b0; // anything outside the enum.
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd_ready <= 1'b0;
		end else begin
			cmd_ready <= cmd_strobe;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_strobe) begin
			cmd <= decoded; // held until the next strobe.
		end
	end

	// the stepper samples the command only in the cycle after the strobe.
	ready_follows_strobe: assert property (@(posedge clk) disable iff (reset)
		cmd_strobe |-> !$isunknown(cmd_word) ##1 cmd_ready);

endmodule

`default_nettype wire

// ==== int_sqrt.sv ====
`timescale 1ns/1ns
`default_nettype none

module int_sqrt (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [plotter_pkg::sq_bits-1:0] radicand,
	output logic [plotter_pkg::pos_bits:0] root,
	output logic done
);
	import plotter_pkg::*;

	logic running;
	logic [$clog2(pos_bits+1)-1:0] iter;
	logic [sq_bits-1:0] rad_sh; // radicand, top bit pair first.
	logic [pos_bits+2:0] rem;
	logic [pos_bits+2:0] rem_next;
	logic [pos_bits+2:0] trial;

	always_comb begin
		rem_next = {rem[pos_bits:0], rad_sh[sq_bits-1 -: 2]}; // bring down two bits.
		trial = {root, 2'b01}; // 4 * root + 1.
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				running <= 1'b1;
			end else if (running && iter == pos_bits) begin
				running <= 1'b0;
				done <= 1'b1; // last result bit is written now.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			rad_sh <= radicand;
			rem <= '0;
			root <= '0;
			iter <= '0;
		end else if (running) begin
			rad_sh <= rad_sh << 2;
			iter <= iter + 1'b1;
			if (rem_next >= trial) begin
				rem <= rem_next - trial;
				root <= {root[pos_bits-1:0], 1'b1};
			end else begin
				rem <= rem_next; // restore.
				root <= {root[pos_bits-1:0], 1'b0};
			end
		end
	end

	no_restart: assert property (@(posedge clk) disable iff (reset)
		start |-> !running);

endmodule

`default_nettype wire

// ==== plotter_patterns.txt ====
# columns: test name, command word in hex (opcode x y i j), then in decimal
# the expected x, expected y, expected step count and expected error flag
move_abs        064640000  100 100  0 0
arc_cw_quarter  2695F00FB  105  95 10 0
arc_ccw_half    35F5FFB00   95  95 20 0
circle_cw       25F5F0500   95  95 40 0
off_circle      3C8C80500   95  95 40 1
bad_opcode      512340000   95  95  0 1
move_home       00A140000   10  20  0 0
arc_cw_low      20F0F00FB   15  15 10 0

// ==== plotter_pkg.sv ====
`default_nettype none

package plotter_pkg;

	localparam int pos_bits = 8; // pen coordinates 0 to 255.
	localparam int off_bits = 8; // signed centre offset.
	localparam int cmd_bits = 36;
	localparam int sq_bits = 2 * (pos_bits + 1);
	localparam int count_bits = 12;

	typedef enum logic [3:0] {
		op_move = 4'd0,
		op_arc_cw = 4'd2,
		op_arc_ccw = 4'd3
	} opcode_t;

	// quadrant of the pen relative to the arc centre.
	typedef enum logic [1:0] {
		q1,
		q2,
		q3,
		q4
	} quadrant_t;

	typedef enum logic [2:0] {
		idle,
		load,
		sqrt_wait,
		step,
		wait_ack,
		finish
	} arc_state_t;

	typedef struct packed {
		opcode_t opcode;
		logic [pos_bits-1:0] x; // target or arc end point.
		logic [pos_bits-1:0] y;
		logic signed [off_bits-1:0] i; // centre offset from the start point.
		logic signed [off_bits-1:0] j;
		logic valid; // low for an unknown opcode.
	} cmd_t;

endpackage

`default_nettype wire

// ==== plotter_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module plotter_top (
	input logic clk,
	input logic reset,
	input logic cmd_strobe,
	input logic [plotter_pkg::cmd_bits-1:0] cmd_word,
	output logic busy,
	output logic done,
	output logic error,
	output logic step_pulse,
	output logic step_axis,
	output logic step_neg,
	output logic [plotter_pkg::pos_bits-1:0] pos_x,
	output logic [plotter_pkg::pos_bits-1:0] pos_y,
	output logic [plotter_pkg::count_bits-1:0] step_count
);
	import plotter_pkg::*;

	cmd_t cmd;
	logic cmd_ready;

	step_if step_bus ();

	cmd_decoder decoder_i (
		.clk(clk),
		.reset(reset),
		.cmd_strobe(cmd_strobe),
		.cmd_word(cmd_word),
		.cmd(cmd),
		.cmd_ready(cmd_ready)
	);

	arc_stepper stepper_i (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.cmd_ready(cmd_ready),
		.step(step_bus.stepper),
		.busy(busy),
		.done(done),
		.error(error),
		.step_count(step_count)
	);

	position_tracker tracker_i (
		.clk(clk),
		.reset(reset),
		.step(step_bus.tracker),
		.step_pulse(step_pulse),
		.step_axis(step_axis),
		.step_neg(step_neg),
		.pos_x(pos_x),
		.pos_y(pos_y)
	);

endmodule

`default_nettype wire

// ==== position_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

module position_tracker (
	input logic clk,
	input logic reset,
	step_if.tracker step,
	output logic step_pulse,
	output logic step_axis,
	output logic step_neg,
	output logic [plotter_pkg::pos_bits-1:0] pos_x,
	output logic [plotter_pkg::pos_bits-1:0] pos_y
);

	logic at_edge; // the requested step would leave the grid.

	assign step.cur_x = pos_x;
	assign step.cur_y = pos_y;

	always_comb begin
		if (step.step_neg) begin
			at_edge = step.step_axis ? (pos_y == '0) : (pos_x == '0);
		end else begin
			at_edge = step.step_axis ? (pos_y == '1) : (pos_x == '1);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pos_x <= '0;
			pos_y <= '0;
			step_pulse <= 1'b0;
		end else begin
			step_pulse <= step.step_req; // visible with the new position.
			if (step.move_req) begin
				pos_x <= step.move_x;
				pos_y <= step.move_y;
			end else if (step.step_req) begin
				if (!step.step_axis) pos_x <= step.step_neg ? pos_x - 1'b1 : pos_x + 1'b1;
				else pos_y <= step.step_neg ? pos_y - 1'b1 : pos_y + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (step.step_req) begin
			step_axis <= step.step_axis;
			step_neg <= step.step_neg;
		end
	end

	no_wrap: assert property (@(posedge clk) disable iff (reset)
		step.step_req |-> !at_edge);

endmodule

`default_nettype wire

// ==== step_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// a request is applied in the cycle after its pulse.
interface step_if;
	import plotter_pkg::*;

	logic step_req; // one unit step.
	logic step_axis; // 0 is x, 1 is y.
	logic step_neg; // step decreases the coordinate.
	logic move_req; // absolute load.
	logic [pos_bits-1:0] move_x;
	logic [pos_bits-1:0] move_y;
	logic [pos_bits-1:0] cur_x; // current pen position.
	logic [pos_bits-1:0] cur_y;

	modport stepper (
		output step_req, step_axis, step_neg,
		output move_req, move_x, move_y,
		input cur_x, cur_y
	);

	modport tracker (
		input step_req, step_axis, step_neg,
		input move_req, move_x, move_y,
		output cur_x, cur_y
	);

endinterface

`default_nettype wire

// ==== tb_plotter.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_plotter;
	import plotter_pkg::*;

	localparam int max_patterns = 32;

	logic clk;
	logic reset;
	logic cmd_strobe;
	logic [cmd_bits-1:0] cmd_word;
	logic busy;
	logic done;
	logic error;
	logic step_pulse;
	logic step_axis;
	logic step_neg;
	logic [pos_bits-1:0] pos_x;
	logic [pos_bits-1:0] pos_y;
	logic [count_bits-1:0] step_count;

	string test_name [max_patterns];
	logic [cmd_bits-1:0] test_word [max_patterns];
	int test_x [max_patterns];
	int test_y [max_patterns];
	int test_steps [max_patterns];
	int test_err [max_patterns];
	int n_patterns;
	int budget_cycles;
	logic budget_ready;
	logic [pos_bits-1:0] model_x; // pen position rebuilt from the step pulses.
	logic [pos_bits-1:0] model_y;

	plotter_top dut_i (
		.clk(clk),
		.reset(reset),
		.cmd_strobe(cmd_strobe),
		.cmd_word(cmd_word),
		.busy(busy),
		.done(done),
		.error(error),
		.step_pulse(step_pulse),
		.step_axis(step_axis),
		.step_neg(step_neg),
		.pos_x(pos_x),
		.pos_y(pos_y),
		.step_count(step_count)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_position(input string name,
		input logic [pos_bits-1:0] exp_px, input logic [pos_bits-1:0] exp_py,
		input logic [pos_bits-1:0] act_px, input logic [pos_bits-1:0] act_py);
		if (exp_px !== act_px || exp_py !== act_py) begin
			fail_run($sformatf("error %s: position expected (%0d,%0d) actual (%0d,%0d)",
				name, exp_px, exp_py, act_px, act_py));
		end
	endtask

	task automatic check_count(input string name, input logic [count_bits-1:0] expected,
		input logic [count_bits-1:0] actual);
		if (expected !== actual) begin
			fail_run($sformatf("error %s: step count expected %0d actual %0d",
				name, expected, actual));
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (expected !== actual) begin
			fail_run($sformatf("error %s: error flag expected %0b actual %0b",
				name, expected, actual));
		end
	endtask

	task automatic load_patterns();
		int fd;
		int fields;
		int ex;
		int ey;
		int es;
		int ee;
		logic [8*160-1:0] line;
		logic [cmd_bits-1:0] word;
		string name;
		fd = $fopen("plotter_patterns.txt", "r");
		if (fd == 0) begin
			fail_run("cannot open plotter_patterns.txt");
		end else begin
			n_patterns = 0;
			while (!$feof(fd)) begin
				line = '0;
				if ($fgets(line, fd) != 0) begin
					// comment and blank lines never yield all six fields.
					fields = $sscanf(line, "%s %h %d %d %d %d", name, word, ex, ey, es, ee);
					if (fields == 6 && n_patterns < max_patterns) begin
						test_name[n_patterns] = name;
						test_word[n_patterns] = word;
						test_x[n_patterns] = ex;
						test_y[n_patterns] = ey;
						test_steps[n_patterns] = es;
						test_err[n_patterns] = ee;
						n_patterns++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_pattern(input int k);
		int pulses;
		opcode_t op;
		op = opcode_t'(test_word[k][cmd_bits-1 -: 4]);
		pulses = 0;
		@(negedge clk);
		if (busy) begin
			fail_run({test_name[k], ": busy is still high before the command"});
		end
		@(posedge clk);
		cmd_strobe <= 1'b1;
		cmd_word <= test_word[k];
		@(posedge clk);
		cmd_strobe <= 1'b0;
		do begin
			@(negedge clk);
			if (step_pulse) begin
				pulses++;
				if (!step_axis) model_x = step_neg ? model_x - 1'b1 : model_x + 1'b1;
				else model_y = step_neg ? model_y - 1'b1 : model_y + 1'b1;
				// one unit per pulse, so the model tracks the pen exactly.
				check_position({test_name[k], " step"}, model_x, model_y, pos_x, pos_y);
			end
		end while (!done);
		if (op == op_move) begin
			model_x = test_word[k][4*pos_bits-1 -: pos_bits];
			model_y = test_word[k][3*pos_bits-1 -: pos_bits];
		end
		check_position(test_name[k], test_x[k], test_y[k], pos_x, pos_y);
		check_position({test_name[k], " model"}, test_x[k], test_y[k], model_x, model_y);
		check_count(test_name[k], test_steps[k], step_count);
		check_count({test_name[k], " pulses"}, test_steps[k], pulses);
		check_flag(test_name[k], test_err[k][0], error);
	endtask

	initial begin
		int unsigned seed;
		int idle;
		seed = 32'hb6bf_f254;
		void'($urandom(seed));
		reset = 1'b1;
		cmd_strobe = 1'b0;
		cmd_word = '0;
		model_x = '0;
		model_y = '0;
		budget_ready = 1'b0;
		load_patterns();
		budget_cycles = 10; // reset.
		for (int k = 0; k < n_patterns; k++) begin
			budget_cycles += 40 + 20 * test_steps[k] + 5; // 5 covers the idle gap.
		end
		budget_ready = 1'b1;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		for (int k = 0; k < n_patterns; k++) begin
			idle = $urandom % 6;
			repeat (idle) @(posedge clk);
			run_pattern(k);
		end
		if (n_patterns == 0) begin
			fail_run("no patterns were read from plotter_patterns.txt");
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

	initial begin
		wait (budget_ready);
		repeat (budget_cycles) @(posedge clk);
		$display("watchdog: the run did not finish within %0d cycles", budget_cycles);
		$display("=== FAIL ===");
		$fatal(1);
	end

endmodule

`default_nettype wire
